//--- Makefile
# Verilator build and run for the memory-error logging testbench.
# Every variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= tb_mem_err
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SOURCES := $(FLIST) $(wildcard src/*.sv) $(wildcard sim/*.sv) $(wildcard sim/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build products and the log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "** PASS **" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
+incdir+sim
src/mem_err_pkg.sv
src/ecc_syndrome_check.sv
src/parity_error_log.sv
src/apb_error_regs.sv
src/mem_err_top.sv
sim/tb_mem_err.sv

//--- sim/tb_ecc_model.svh
/*
  Reference model for the memory-error testbench, included inside its top module.
  Provides an independent SEC-DED encoder, a classifier for injected bit flips
  and a builder for the expected PES word.
*/
`ifndef TB_ECC_MODEL_SVH
`define TB_ECC_MODEL_SVH

// Codeword position of data bit j: the j-th position that is not a power of two.
function automatic logic [4:0] data_position(input int j);
  int p;
  int k;
  p = 0;
  k = -1;
  while (k < j) begin
    p++;
    if ((p & (p - 1)) != 0) k++;
  end
  return p[4:0];
endfunction

// Position of bit b of the 22-bit vector {check, data}.
// The overall parity bit sits outside the Hamming positions and counts as 0.
function automatic logic [4:0] codeword_position(input int b);
  if (b < 16) return data_position(b);
  if (b < 21) return 5'(1 << (b - 16));
  return 5'd0;
endfunction

// Check bits are the XOR of the positions of all set data bits.
// The overall bit then makes the full codeword even.
function automatic logic [5:0] encode_check(input logic [15:0] d);
  logic [5:0] c;
  c = '0;
  for (int j = 0; j < 16; j++) begin
    if (d[j]) c[4:0] = c[4:0] ^ data_position(j);
  end
  c[5] = ^{d, c[4:0]};
  return c;
endfunction

// Returns {fatal, code} for a set of flipped codeword bits.
// One flip is corrected; two flips are fatal; the code is the syndrome either way.
function automatic logic [5:0] classify_flips(input logic [21:0] flips);
  logic [4:0] syn;
  syn = '0;
  for (int b = 0; b < 22; b++) begin
    if (flips[b]) syn = syn ^ codeword_position(b);
  end
  return {($countones(flips) >= 2), syn};
endfunction

// PES layout is FETCH, DMA, FATAL, 5-bit code, then address bits 23 to 16.
function automatic logic [15:0] build_pes(input logic fetch, input logic dma,
                                          input logic fatal, input logic [4:0] code,
                                          input logic [23:0] addr);
  return {fetch, dma, fatal, code, addr[23:16]};
endfunction

`endif

//--- sim/tb_mem_err.sv
/*
  Random-stimulus testbench for the memory-error logging subsystem.
  Sends clean and corrupted references, then reads the log over APB and
  compares everything with the included reference model.
*/
`timescale 1ns/100ps

module tb_mem_err;

  // Length of the test; the watchdog limit follows from these.
  localparam int n_clean   = 20;
  localparam int n_rounds  = 40;
  localparam int max_burst = 8;
  localparam int n_sat     = 300;
  localparam int max_refs  = n_clean + n_rounds * (max_burst + 2) + n_sat + 6;
  localparam int max_apb   = 3 + n_rounds * 9 + 3;
  localparam int timeout_ns = 4 * (max_refs * 4 + max_apb * 3 + 200);

  logic        clk;
  logic        rst_n;
  logic        mem_valid;
  logic [23:0] mem_addr;
  logic [15:0] mem_data;
  logic [5:0]  mem_check;
  logic        mem_fetch;
  logic        mem_dma;
  logic        rd_valid;
  logic [15:0] rd_data;
  logic        rd_fatal;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        err_irq;

  // Expected log state, kept by the model.
  logic [15:0] exp_pes;
  logic [15:0] exp_pea;
  logic [31:0] exp_cnt;
  logic        exp_pending;

  // Expected read response of the reference issued in the previous cycle.
  logic        chk_valid;
  logic [15:0] chk_data;
  logic        chk_fatal;

  `include "tb_ecc_model.svh"

  mem_err_top #(.cnt_w(8)) UUT (
    .clk(clk), .rst_n(rst_n),
    .mem_valid(mem_valid), .mem_addr(mem_addr), .mem_data(mem_data),
    .mem_check(mem_check), .mem_fetch(mem_fetch), .mem_dma(mem_dma),
    .rd_valid(rd_valid), .rd_data(rd_data), .rd_fatal(rd_fatal),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .err_irq(err_irq)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(timeout_ns);
    $display("Run timed out before all tests finished.");
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      $display("** FAIL **");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Compares the checker outputs with the reference sent one cycle earlier.
  task automatic check_outputs();
    check_value("rd_valid", {31'b0, rd_valid}, {31'b0, chk_valid});
    if (chk_valid) begin
      check_value("rd_data", {16'h0, rd_data}, {16'h0, chk_data});
      check_value("rd_fatal", {31'b0, rd_fatal}, {31'b0, chk_fatal});
    end
  endtask

  // Sends one reference with nflip corrupted codeword bits and updates the model.
  task automatic issue_ref(input int nflip, input logic fetch, input logic dma);
    logic [15:0] data;
    logic [23:0] addr;
    logic [21:0] cw;
    logic [21:0] flips;
    logic [5:0]  cls;
    int b0;
    int b1;
    data  = 16'($urandom);
    addr  = 24'($urandom);
    cw    = {encode_check(data), data};
    flips = '0;
    b0 = $urandom_range(21, 0);
    b1 = $urandom_range(21, 0);
    while (b1 == b0) b1 = $urandom_range(21, 0);
    if (nflip >= 1) flips[b0] = 1'b1;
    if (nflip >= 2) flips[b1] = 1'b1;
    cw  = cw ^ flips;
    cls = classify_flips(flips);
    @(negedge clk);
    check_outputs();
    mem_valid = 1'b1;
    mem_addr  = addr;
    mem_data  = cw[15:0];
    mem_check = cw[21:16];
    mem_fetch = fetch;
    mem_dma   = dma;
    chk_valid = 1'b1;
    // A fatal reference comes back uncorrected.
    chk_data  = cls[5] ? cw[15:0] : data;
    chk_fatal = cls[5];
    if (nflip > 0) begin
      exp_pes = build_pes(fetch, dma, cls[5], cls[4:0], addr);
      exp_pea = addr[15:0];
      if (exp_cnt < 255) exp_cnt = exp_cnt + 1;
      exp_pending = 1'b1;
    end
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    check_outputs();
    mem_valid = 1'b0;
    chk_valid = 1'b0;
  endtask

  // One APB transfer; the response is sampled inside the access cycle.
  task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #1;
    rdata = prdata;
    err   = pslverr;
    check_value("pready", {31'b0, pready}, 32'h1);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_reg(input logic [3:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b0, addr, 32'h0, rdata, err);
    check_value("pslverr", {31'b0, err}, 32'h0);
    check_value(name, rdata, exp);
  endtask

  task automatic clear_count();
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, mem_err_pkg::reg_cnt, $urandom, rdata, err);
    check_value("pslverr", {31'b0, err}, 32'h0);
    exp_cnt = 0;
    read_reg(mem_err_pkg::reg_cnt, exp_cnt, "err_count");
  endtask

  // Illegal accesses must fail and must not disturb the pending flag.
  task automatic try_bad_accesses();
    logic [31:0] rdata;
    logic        err;
    apb_xfer(1'b1, mem_err_pkg::reg_pes, $urandom, rdata, err);
    check_value("pslverr", {31'b0, err}, 32'h1);
    apb_xfer(1'b1, mem_err_pkg::reg_pea, $urandom, rdata, err);
    check_value("pslverr", {31'b0, err}, 32'h1);
    apb_xfer(1'b0, 4'hC, 32'h0, rdata, err);
    check_value("pslverr", {31'b0, err}, 32'h1);
    apb_xfer(1'b1, 4'hC, $urandom, rdata, err);
    check_value("pslverr", {31'b0, err}, 32'h1);
    check_value("err_irq", {31'b0, err_irq}, {31'b0, exp_pending});
  endtask

  initial begin
    int len;
    void'($urandom(32'h96e8809f));
    rst_n = 1'b0;
    mem_valid = 1'b0;
    mem_addr = '0;
    mem_data = '0;
    mem_check = '0;
    mem_fetch = 1'b0;
    mem_dma = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    exp_pes = '0;
    exp_pea = '0;
    exp_cnt = 0;
    exp_pending = 1'b0;
    chk_valid = 1'b0;
    chk_data = '0;
    chk_fatal = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check_value("err_irq", {31'b0, err_irq}, 32'h0);
    // Clean references leave the log exactly as reset left it.
    for (int i = 0; i < n_clean; i++) issue_ref(0, 1'($urandom), 1'($urandom));
    idle_cycle();
    idle_cycle();
    check_value("err_irq", {31'b0, err_irq}, 32'h0);
    read_reg(mem_err_pkg::reg_pes, 32'h0, "pes_word");
    read_reg(mem_err_pkg::reg_pea, 32'h0, "pea_word");
    read_reg(mem_err_pkg::reg_cnt, 32'h0, "err_count");
    // Mixed bursts of clean, single and double errors, each followed by a register check.
    for (int r = 0; r < n_rounds; r++) begin
      len = $urandom_range(max_burst, 1);
      for (int i = 0; i < len; i++) begin
        issue_ref($urandom_range(2, 0), 1'($urandom), 1'($urandom));
      end
      idle_cycle();
      idle_cycle();
      check_value("err_irq", {31'b0, err_irq}, {31'b0, exp_pending});
      try_bad_accesses();
      read_reg(mem_err_pkg::reg_pea, {16'h0, exp_pea}, "pea_word");
      check_value("err_irq", {31'b0, err_irq}, {31'b0, exp_pending});
      read_reg(mem_err_pkg::reg_cnt, exp_cnt, "err_count");
      read_reg(mem_err_pkg::reg_pes, {16'h0, exp_pes}, "pes_word");
      exp_pending = 1'b0;
      check_value("err_irq", {31'b0, err_irq}, 32'h0);
      if (r % 8 == 7) clear_count();
    end
    // A long run of errors drives the counter into saturation.
    clear_count();
    for (int i = 0; i < n_sat; i++) issue_ref($urandom_range(2, 1), 1'($urandom), 1'($urandom));
    idle_cycle();
    idle_cycle();
    read_reg(mem_err_pkg::reg_cnt, exp_cnt, "err_count");
    read_reg(mem_err_pkg::reg_pes, {16'h0, exp_pes}, "pes_word");
    $display("** PASS **");
    $finish;
  end

endmodule

//--- src/apb_error_regs.sv
/*
  APB slave for the error log.
  PES, PEA and the error count are readable; a PES read clears the pending
  interrupt and a write to the count register clears the count.
*/
`timescale 1ns/100ps

module apb_error_regs #(
  parameter int cnt_w = 8
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [3:0]                     paddr,
  input  logic [31:0]                    pwdata,
  input  logic [mem_err_pkg::data_w-1:0] pes_word,
  input  logic [mem_err_pkg::data_w-1:0] pea_word,
  input  logic [cnt_w-1:0]               err_count,
  output logic [31:0]                    prdata,
  output logic                           pready,
  output logic                           pslverr,
  output logic                           pes_read_ack,
  output logic                           cnt_clear
);

  logic access;
  logic hit_pes;
  logic hit_pea;
  logic hit_cnt;
  logic bad;

  // There are never wait states, so every access cycle completes.
  assign pready = 1'b1;
  assign access = psel && penable;

  assign hit_pes = (paddr == mem_err_pkg::reg_pes);
  assign hit_pea = (paddr == mem_err_pkg::reg_pea);
  assign hit_cnt = (paddr == mem_err_pkg::reg_cnt);

  // Unmapped offsets fail, and so do writes to the two capture registers.
  assign bad     = !(hit_pes || hit_pea || hit_cnt) || (pwrite && (hit_pes || hit_pea));
  assign pslverr = access && bad;

  // Strobes toward the log fire only on transfers that complete without error.
  // The counter is write-to-clear, so the written value carries no meaning.
  assign pes_read_ack = access && !pwrite && hit_pes;
  assign cnt_clear    = access && pwrite && hit_cnt;

  // Read data is taken from the registers as they stand in the access cycle.
  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      if (hit_pes) begin
        prdata = 32'(pes_word);
      end else if (hit_pea) begin
        prdata = 32'(pea_word);
      end else if (hit_cnt) begin
        prdata = 32'(err_count);
      end
    end
  end

endmodule

//--- src/ecc_syndrome_check.sv
/*
  SEC-DED checker on the memory read path.
  Accepts one reference per cycle and, one cycle later, returns corrected
  data and a fatal flag, and reports any failing reference to the error log.
*/
`timescale 1ns/100ps

module ecc_syndrome_check (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               mem_valid,
  input  logic [mem_err_pkg::addr_w-1:0]     mem_addr,
  input  logic [mem_err_pkg::data_w-1:0]     mem_data,
  input  logic [mem_err_pkg::check_w-1:0]    mem_check,
  input  logic                               mem_fetch,
  input  logic                               mem_dma,
  output logic                               rd_valid,
  output logic [mem_err_pkg::data_w-1:0]     rd_data,
  output logic                               rd_fatal,
  output logic                               err_valid,
  output logic [mem_err_pkg::code_w-1:0]     err_code,
  output logic                               err_fatal,
  output logic [mem_err_pkg::addr_w-1:0]     err_addr,
  output logic                               err_fetch,
  output logic                               err_dma
);

  // The syndrome is formed by the five Hamming bits only.
  localparam int syn_w = mem_err_pkg::check_w - 1;

  logic [syn_w-1:0]               syndrome;
  logic                           parity_err;
  logic                           any_err;
  logic                           fatal;
  logic [mem_err_pkg::data_w-1:0] flip;

  // Codeword position of data bit j.
  // Bit i of the position is set exactly when mask i covers that data bit.
  function automatic logic [syn_w-1:0] data_pos(input int j);
    logic [syn_w-1:0] p;
    for (int i = 0; i < syn_w; i++) begin
      p[i] = mem_err_pkg::ham_mask[i][j];
    end
    return p;
  endfunction

  always_comb begin
    // Each syndrome bit compares the stored check bit with the recomputed one.
    for (int i = 0; i < syn_w; i++) begin
      syndrome[i] = ^(mem_data & mem_err_pkg::ham_mask[i]) ^ mem_check[i];
    end
    // The overall bit makes the whole 22-bit codeword even, so any odd
    // number of flipped bits shows up here.
    parity_err = ^{mem_data, mem_check};
    any_err    = (syndrome != '0) || parity_err;
    // An even flip count with a nonzero syndrome cannot be corrected.
    fatal      = (syndrome != '0) && !parity_err;
    // A single error points at its position.
    // Only data positions need flipping back; a hit on a check bit leaves the data alone.
    for (int j = 0; j < mem_err_pkg::data_w; j++) begin
      flip[j] = parity_err && (syndrome == data_pos(j));
    end
  end

  // Control flags of the output stage.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_valid  <= 1'b0;
      rd_fatal  <= 1'b0;
      err_valid <= 1'b0;
    end else begin
      rd_valid  <= mem_valid;
      rd_fatal  <= mem_valid && fatal;
      err_valid <= mem_valid && any_err;
    end
  end

  // Payload of the output stage, loaded with each accepted reference.
  // The error code is the syndrome itself; it reads 0 when only the overall bit failed.
  always_ff @(posedge clk) begin
    if (mem_valid) begin
      rd_data   <= mem_data ^ flip;
      err_code  <= syndrome;
      err_fatal <= fatal;
      err_addr  <= mem_addr;
      err_fetch <= mem_fetch;
      err_dma   <= mem_dma;
    end
  end

endmodule

//--- src/mem_err_pkg.sv
/*
  Shared definitions for the memory-error logging subsystem.
  Bus widths, the PES field layout, APB register offsets and the SEC-DED
  check masks live here, and every module refers to them by scoped name.
*/
package mem_err_pkg;

  // Physical address, data and check-bit widths of a memory reference.
  localparam int addr_w  = 24;
  localparam int data_w  = 16;
  localparam int check_w = 6;

  // Error code width, which is wide enough to name any codeword position.
  localparam int code_w = 5;

  // PES layout. FETCH, DMA and FATAL sit in the top three bits.
  localparam int pes_fetch_bit = 15;
  localparam int pes_dma_bit   = 14;
  localparam int pes_fatal_bit = 13;
  // The error code fills bits 12 to 8.
  // Everything below it holds address bits 23 to 16.
  localparam int pes_code_lsb  = 8;

  // APB byte offsets of the three readable registers.
  localparam logic [3:0] reg_pes = 4'h0;
  localparam logic [3:0] reg_pea = 4'h4;
  localparam logic [3:0] reg_cnt = 4'h8;

  // Hamming masks, one per check bit. Data bit j sits at the j-th codeword
  // position that is not a power of two (3, 5, 6, 7, 9 ... 21), and mask i
  // selects the data bits whose position has bit i set.
  // The overall parity bit (check bit 5) covers all data and all five check bits.
  localparam logic [check_w-2:0][data_w-1:0] ham_mask = {
    16'hF800,
    16'h07F0,
    16'hC78E,
    16'h366D,
    16'hAD5B
  };

endpackage

//--- src/mem_err_top.sv
/*
  Top level of the memory-error logging subsystem.
  Connects the SEC-DED checker, the capture log and the APB register port,
  and sets the width of the saturating error counter.
*/
`timescale 1ns/100ps

module mem_err_top #(
  parameter int cnt_w = 8
) (
  input  logic                            clk,
  input  logic                            rst_n,
  // Memory read side.
  input  logic                            mem_valid,
  input  logic [mem_err_pkg::addr_w-1:0]  mem_addr,
  input  logic [mem_err_pkg::data_w-1:0]  mem_data,
  input  logic [mem_err_pkg::check_w-1:0] mem_check,
  input  logic                            mem_fetch,
  input  logic                            mem_dma,
  output logic                            rd_valid,
  output logic [mem_err_pkg::data_w-1:0]  rd_data,
  output logic                            rd_fatal,
  // APB side.
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [3:0]                      paddr,
  input  logic [31:0]                     pwdata,
  output logic [31:0]                     prdata,
  output logic                            pready,
  output logic                            pslverr,
  // Pending error interrupt.
  output logic                            err_irq
);

  logic                           err_valid;
  logic [mem_err_pkg::code_w-1:0] err_code;
  logic                           err_fatal;
  logic [mem_err_pkg::addr_w-1:0] err_addr;
  logic                           err_fetch;
  logic                           err_dma;
  logic [mem_err_pkg::data_w-1:0] pes_word;
  logic [mem_err_pkg::data_w-1:0] pea_word;
  logic [cnt_w-1:0]               err_count;
  logic                           pes_read_ack;
  logic                           cnt_clear;

  // Checker, one register stage behind the memory.
  ecc_syndrome_check u_check (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_valid (mem_valid),
    .mem_addr  (mem_addr),
    .mem_data  (mem_data),
    .mem_check (mem_check),
    .mem_fetch (mem_fetch),
    .mem_dma   (mem_dma),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data),
    .rd_fatal  (rd_fatal),
    .err_valid (err_valid),
    .err_code  (err_code),
    .err_fatal (err_fatal),
    .err_addr  (err_addr),
    .err_fetch (err_fetch),
    .err_dma   (err_dma)
  );

  // Log, capturing one cycle after the checker reports.
  parity_error_log #(
    .cnt_w (cnt_w)
  ) u_log (
    .clk          (clk),
    .rst_n        (rst_n),
    .err_valid    (err_valid),
    .err_code     (err_code),
    .err_fatal    (err_fatal),
    .err_addr     (err_addr),
    .err_fetch    (err_fetch),
    .err_dma      (err_dma),
    .pes_read_ack (pes_read_ack),
    .cnt_clear    (cnt_clear),
    .pes_word     (pes_word),
    .pea_word     (pea_word),
    .err_count    (err_count),
    .err_irq      (err_irq)
  );

  // CPU access to the log.
  apb_error_regs #(
    .cnt_w (cnt_w)
  ) u_apb (
    .clk          (clk),
    .rst_n        (rst_n),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .pes_word     (pes_word),
    .pea_word     (pea_word),
    .err_count    (err_count),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .pes_read_ack (pes_read_ack),
    .cnt_clear    (cnt_clear)
  );

endmodule

//--- src/parity_error_log.sv
/*
  Capture log for failing memory references.
  Keeps PES and PEA of the most recent error, a pending flag that drives the
  interrupt, and a saturating count of errors since the last clear.
*/
`timescale 1ns/100ps

module parity_error_log #(
  parameter int cnt_w = 8
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           err_valid,
  input  logic [mem_err_pkg::code_w-1:0] err_code,
  input  logic                           err_fatal,
  input  logic [mem_err_pkg::addr_w-1:0] err_addr,
  input  logic                           err_fetch,
  input  logic                           err_dma,
  input  logic                           pes_read_ack,
  input  logic                           cnt_clear,
  output logic [mem_err_pkg::data_w-1:0] pes_word,
  output logic [mem_err_pkg::data_w-1:0] pea_word,
  output logic [cnt_w-1:0]               err_count,
  output logic                           err_irq
);

  logic [mem_err_pkg::data_w-1:0] pes_next;

  // Assemble the status word from the failing reference.
  always_comb begin
    pes_next = '0;
    pes_next[mem_err_pkg::pes_fetch_bit] = err_fetch;
    pes_next[mem_err_pkg::pes_dma_bit]   = err_dma;
    pes_next[mem_err_pkg::pes_fatal_bit] = err_fatal;
    pes_next[mem_err_pkg::pes_code_lsb +: mem_err_pkg::code_w] = err_code;
    // The low byte carries the upper address bits 23 to 16.
    pes_next[mem_err_pkg::pes_code_lsb-1:0] =
      err_addr[mem_err_pkg::addr_w-1 -: mem_err_pkg::pes_code_lsb];
  end

  // PES and PEA hold only the last failing reference.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pes_word <= '0;
      pea_word <= '0;
    end else if (err_valid) begin
      pes_word <= pes_next;
      pea_word <= err_addr[mem_err_pkg::data_w-1:0];
    end
  end

  // Pending flag. A new capture wins over a PES read in the same cycle.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_irq <= 1'b0;
    end else if (err_valid) begin
      err_irq <= 1'b1;
    end else if (pes_read_ack) begin
      err_irq <= 1'b0;
    end
  end

  // Error counter, saturating at all ones.
  // A clear that meets a capture leaves exactly that one error counted.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_count <= '0;
    end else if (err_valid) begin
      if (cnt_clear) begin
        err_count <= cnt_w'(1);
      end else if (err_count != '1) begin
        err_count <= err_count + 1'b1;
      end
    end else if (cnt_clear) begin
      err_count <= '0;
    end
  end

endmodule
